// ==== list.f ====
src/uncore_pkg.sv
src/dev_bus_if.sv
src/uncore_ctrl.sv
src/cfg_regs.sv
src/clint_slice.sv
src/uncore_top.sv
sim/tb_uncore.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the uncore testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 -f list.f --top-module tb_uncore -o sim_uncore
./obj_dir/sim_uncore | tee sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  echo "uncore simulation passed"
else
  echo "uncore simulation failed"
  exit 1
fi

// ==== sim/tb_uncore.sv ====
module tb_uncore;
  timeunit 1ns;
  timeprecision 1ps;
  import uncore_pkg::*;

  localparam int          CLK_HALF   = 20;
  localparam int          RST_CYCLES = 4;
  localparam int          SETTLE     = 5;
  localparam logic [31:0] SEED       = 32'd95454;
  localparam int          N_CFG      = 4;
  localparam int          N_TILE     = 4;
  localparam int          N_LOOP     = 4;
  localparam int          N_RAND     = 60;
  localparam int          N_TXN = 4 * N_CFG + 3 * N_TILE + 2 * N_LOOP + 6 + NUM_SRC * N_RAND;

  logic               clk, rst_n;
  logic [NUM_SRC-1:0] cmd_v, cmd_ready, resp_v, resp_ready, outstanding;
  mem_op_e            cmd_op [NUM_SRC];
  logic [ADDR_W-1:0]  cmd_addr [NUM_SRC];
  logic [DATA_W-1:0]  cmd_data [NUM_SRC];
  logic [DATA_W-1:0]  resp_data [NUM_SRC];
  logic               mem_cmd_v, mem_cmd_ready, mem_resp_v, mem_resp_ready;
  mem_op_e            mem_cmd_op;
  logic [ADDR_W-1:0]  mem_cmd_addr;
  logic [DATA_W-1:0]  mem_cmd_data, mem_resp_data;
  logic               freeze, timer_irq, software_irq;

  // Reference model state
  logic [31:0]       rng;
  logic              m_freeze, m_msip;
  logic [TILE_W-1:0] m_core_id;
  logic [DATA_W-1:0] m_mtimecmp;
  logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
  mem_op_e           exp_mem_op;
  logic [ADDR_W-1:0] exp_mem_addr;
  logic [DATA_W-1:0] exp_mem_data;
  int                mem_expected, mem_cmd_count;
  int                accept_count [NUM_SRC];
  int                resp_count [NUM_SRC];

  uncore_top DUT
  (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .cpu_cmd_v_i      (cmd_v[0]),
    .cpu_cmd_ready_o  (cmd_ready[0]),
    .cpu_cmd_op_i     (cmd_op[0]),
    .cpu_cmd_addr_i   (cmd_addr[0]),
    .cpu_cmd_data_i   (cmd_data[0]),
    .cpu_resp_v_o     (resp_v[0]),
    .cpu_resp_ready_i (resp_ready[0]),
    .cpu_resp_data_o  (resp_data[0]),
    .io_cmd_v_i       (cmd_v[1]),
    .io_cmd_ready_o   (cmd_ready[1]),
    .io_cmd_op_i      (cmd_op[1]),
    .io_cmd_addr_i    (cmd_addr[1]),
    .io_cmd_data_i    (cmd_data[1]),
    .io_resp_v_o      (resp_v[1]),
    .io_resp_ready_i  (resp_ready[1]),
    .io_resp_data_o   (resp_data[1]),
    .mem_cmd_v_o      (mem_cmd_v),
    .mem_cmd_ready_i  (mem_cmd_ready),
    .mem_cmd_op_o     (mem_cmd_op),
    .mem_cmd_addr_o   (mem_cmd_addr),
    .mem_cmd_data_o   (mem_cmd_data),
    .mem_resp_v_i     (mem_resp_v),
    .mem_resp_ready_o (mem_resp_ready),
    .mem_resp_data_i  (mem_resp_data),
    .freeze_o         (freeze),
    .timer_irq_o      (timer_irq),
    .software_irq_o   (software_irq)
  );

  initial
  begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic [ADDR_W-1:0] local_addr(input logic [TILE_W-1:0] tile,
                                                   input logic [DEV_W-1:0] dev,
                                                   input logic [OFFSET_W-1:0] ofs);
    return {4'h0, tile, dev, ofs};
  endfunction

  // Map device numbers 1 and 2 away so the address lands on loopback
  function automatic logic [DEV_W-1:0] unmapped_dev(input logic [DEV_W-1:0] d);
    return (d == CFG_DEV || d == CLINT_DEV) ? d + 4'd4 : d;
  endfunction

  function automatic logic [DATA_W-1:0] mem_peek(input logic [ADDR_W-1:0] addr);
    if (mem.exists(addr))
      return mem[addr];
    return {addr ^ 32'hA5C3_3C5A, ~addr};
  endfunction

  function automatic dest_e route(input logic [ADDR_W-1:0] addr);
    if (addr >= DRAM_BASE || addr[27:24] != m_core_id)
      return DEST_MEM;
    if (addr[23:20] == CFG_DEV)
      return DEST_CFG;
    if (addr[23:20] == CLINT_DEV)
      return DEST_CLINT;
    return DEST_LOOP;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [DATA_W-1:0] got,
                       input logic [DATA_W-1:0] exp);
    if (got !== exp)
      fail_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
  endtask

  // Applies an accepted command to the model and returns its expected response
  task automatic predict(input mem_op_e op, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] data, output logic [DATA_W-1:0] exp,
                         output logic known);
    logic                wr;
    logic [OFFSET_W-1:0] ofs;
    wr    = (op == MEM_WR);
    ofs   = addr[OFFSET_W-1:0];
    exp   = '0;
    known = 1'b1;
    case (route(addr))
      DEST_MEM:
      begin
        exp_mem_op   = op;
        exp_mem_addr = addr;
        exp_mem_data = data;
        mem_expected++;
        if (!wr)
          exp = mem_peek(addr);
      end
      DEST_CFG:
        if (ofs == CFG_FREEZE_OFS)
        begin
          if (wr)
            m_freeze = data[0];
          else
            exp = 64'(m_freeze);
        end
        else if (ofs == CFG_CORE_ID_OFS)
        begin
          if (wr)
            m_core_id = data[TILE_W-1:0];
          else
            exp = 64'(m_core_id);
        end
      DEST_CLINT:
        if (ofs == CLINT_MSIP_OFS)
        begin
          if (wr)
            m_msip = data[0];
          else
            exp = 64'(m_msip);
        end
        else if (ofs == CLINT_MTIMECMP_OFS)
        begin
          if (wr)
            m_mtimecmp = data;
          else
            exp = m_mtimecmp;
        end
        else if (ofs == CLINT_MTIME_OFS)
          known = wr;
      default: exp = '0;
    endcase
  endtask

  task automatic issue(input logic src, input mem_op_e op, input logic [ADDR_W-1:0] addr,
                       input logic [DATA_W-1:0] data, output logic [DATA_W-1:0] rdata);
    logic [DATA_W-1:0] exp;
    logic              known;
    logic              done;
    logic [31:0]       r;
    @(negedge clk);
    cmd_v[src]    = 1'b1;
    cmd_op[src]   = op;
    cmd_addr[src] = addr;
    cmd_data[src] = data;
    done = 1'b0;
    while (!done)
    begin
      #SETTLE;
      if (cmd_ready[src])
      begin
        predict(op, addr, data, exp, known);
        outstanding[src] = 1'b1;
        accept_count[src]++;
        done = 1'b1;
      end
      @(negedge clk);
    end
    cmd_v[src] = 1'b0;
    done = 1'b0;
    while (!done)
    begin
      r = rand32();
      resp_ready[src] = (r[1:0] != 2'b00);
      #SETTLE;
      if (resp_v[src] && resp_ready[src])
      begin
        rdata = resp_data[src];
        done  = 1'b1;
      end
      @(negedge clk);
    end
    resp_ready[src]  = 1'b0;
    outstanding[src] = 1'b0;
    if (known)
      check(src ? "io_resp_data_o" : "cpu_resp_data_o", rdata, exp);
  endtask

  task automatic run_random(input logic src);
    logic [31:0]       r;
    logic [DATA_W-1:0] rd;
    logic [ADDR_W-1:0] a;
    mem_op_e           op;
    for (int i = 0; i < N_RAND; i++)
    begin
      r  = rand32();
      op = r[8] ? MEM_WR : MEM_RD;
      case (r[2:0])
        3'd4:
        begin
          a  = local_addr(m_core_id, CLINT_DEV, CLINT_MTIMECMP_OFS);
          op = MEM_RD;
        end
        3'd5: a = local_addr(m_core_id, unmapped_dev(r[15:12]), {8'h0, r[27:16]});
        3'd6:
        begin
          a  = local_addr(m_core_id, CFG_DEV, CFG_CORE_ID_OFS);
          op = MEM_RD;
        end
        3'd7: a = local_addr(m_core_id ^ (r[15:12] | 4'd1), CFG_DEV, CFG_FREEZE_OFS);
        // Small DRAM window so reads often hit earlier writes
        default: a = DRAM_BASE + {21'h0, r[19:12], 3'b000};
      endcase
      issue(src, op, a, {rand32(), rand32()}, rd);
      repeat (r[31:30]) @(negedge clk);
    end
  endtask

  initial
  begin : mem_responder
    logic [31:0]       mem_rng;
    logic              pend;
    int                delay;
    logic [DATA_W-1:0] word;
    mem_rng       = SEED;
    pend          = 1'b0;
    delay         = 0;
    word          = '0;
    mem_cmd_count = 0;
    mem_cmd_ready = 1'b0;
    mem_resp_v    = 1'b0;
    mem_resp_data = '0;
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge clk);
      mem_rng       = xorshift32(mem_rng);
      mem_cmd_ready = mem_rng[0] | mem_rng[1];
      if (pend && delay == 0)
      begin
        mem_resp_v    = 1'b1;
        mem_resp_data = word;
      end
      else
      begin
        mem_resp_v = 1'b0;
        if (delay > 0)
          delay--;
      end
      #SETTLE;
      if (mem_cmd_v && mem_cmd_count >= mem_expected)
        fail_run("A memory command appeared without a matching accepted command");
      if (mem_cmd_v && mem_cmd_ready)
      begin
        check("mem_cmd_op_o", 64'(mem_cmd_op), 64'(exp_mem_op));
        check("mem_cmd_addr_o", 64'(mem_cmd_addr), 64'(exp_mem_addr));
        check("mem_cmd_data_o", mem_cmd_data, exp_mem_data);
        if (mem_cmd_op == MEM_WR)
        begin
          mem[mem_cmd_addr] = mem_cmd_data;
          word = '0;
        end
        else
          word = mem_peek(mem_cmd_addr);
        pend  = 1'b1;
        delay = int'(mem_rng[3:2]);
        mem_cmd_count++;
      end
      if (mem_resp_v && mem_resp_ready)
        pend = 1'b0;
    end
  end

  initial
  begin : resp_monitor
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge clk);
      #SETTLE;
      if ((resp_v & ~outstanding) != '0)
        fail_run("A response arrived at a requester with no command in flight");
      // Transfer completes at the next rising edge
      for (int s = 0; s < NUM_SRC; s++)
        if (resp_v[s] && resp_ready[s])
          resp_count[s]++;
    end
  end

  initial
  begin : watchdog
    repeat (RST_CYCLES + 200 * N_TXN) @(posedge clk);
    fail_run("Timeout: the tests did not finish in the expected number of cycles");
  end

  initial
  begin : main
    logic [DATA_W-1:0] rd, t0;
    logic [31:0]       r;
    logic [DEV_W-1:0]  dev;
    logic              src;
    int                cnt;
    rng          = SEED;
    m_freeze     = 1'b1;
    m_msip       = 1'b0;
    m_core_id    = '0;
    m_mtimecmp   = '1;
    mem_expected = 0;
    rst_n        = 1'b0;
    cmd_v        = '0;
    resp_ready   = '0;
    outstanding  = '0;
    cmd_op[0]    = MEM_RD;
    cmd_op[1]    = MEM_RD;
    cmd_addr[0]  = '0;
    cmd_addr[1]  = '0;
    cmd_data[0]  = '0;
    cmd_data[1]  = '0;
    accept_count[0] = 0;
    accept_count[1] = 0;
    resp_count[0]   = 0;
    resp_count[1]   = 0;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    check("freeze_o", 64'(freeze), 64'd1);
    check("timer_irq_o", 64'(timer_irq), 64'd0);
    check("software_irq_o", 64'(software_irq), 64'd0);
    check("cmd_ready_o", 64'(cmd_ready), 64'd0);
    check("resp_v", 64'(resp_v), 64'd0);
    check("mem_cmd_v_o", 64'(mem_cmd_v), 64'd0);
    check("mem_resp_ready_o", 64'(mem_resp_ready), 64'd0);

    for (int i = 0; i < N_CFG; i++)
    begin
      r   = rand32();
      src = r[0];
      issue(src, MEM_WR, local_addr(m_core_id, CFG_DEV, CFG_FREEZE_OFS), 64'(r[1]), rd);
      check("freeze_o", 64'(freeze), 64'(m_freeze));
      issue(src, MEM_RD, local_addr(m_core_id, CFG_DEV, CFG_FREEZE_OFS), {r, r}, rd);
      issue(src, MEM_WR, local_addr(m_core_id, CFG_DEV, CFG_CORE_ID_OFS), 64'(r[7:4]), rd);
      issue(src, MEM_RD, local_addr(m_core_id, CFG_DEV, CFG_CORE_ID_OFS), '0, rd);
    end

    // Off-tile addresses leave through the memory port
    for (int i = 0; i < N_TILE; i++)
    begin
      r = rand32();
      issue(r[0], MEM_WR, local_addr(m_core_id, CFG_DEV, CFG_CORE_ID_OFS), 64'(r[7:4]), rd);
      cnt = mem_cmd_count;
      issue(r[1], MEM_RD, local_addr(m_core_id ^ (r[11:8] | 4'd1), CFG_DEV,
                                     CFG_CORE_ID_OFS), {r, r}, rd);
      check("mem_cmd count off tile", 64'(mem_cmd_count), 64'(cnt + 1));
      cnt = mem_cmd_count;
      issue(r[2], MEM_RD, local_addr(m_core_id, CFG_DEV, CFG_CORE_ID_OFS), {r, r}, rd);
      check("mem_cmd count own tile", 64'(mem_cmd_count), 64'(cnt));
    end

    for (int i = 0; i < N_LOOP; i++)
    begin
      r   = rand32();
      dev = unmapped_dev(r[3:0]);
      cnt = mem_cmd_count;
      issue(r[4], MEM_WR, local_addr(m_core_id, dev, r[31:12]), {r, ~r}, rd);
      issue(r[5], MEM_RD, local_addr(m_core_id, dev, r[31:12]), '0, rd);
      check("mem_cmd count loopback", 64'(mem_cmd_count), 64'(cnt));
    end

    issue(1'b0, MEM_WR, local_addr(m_core_id, CLINT_DEV, CLINT_MSIP_OFS), 64'd1, rd);
    check("software_irq_o", 64'(software_irq), 64'd1);
    issue(1'b1, MEM_WR, local_addr(m_core_id, CLINT_DEV, CLINT_MSIP_OFS), 64'd0, rd);
    check("software_irq_o", 64'(software_irq), 64'd0);
    issue(1'b0, MEM_WR, local_addr(m_core_id, CLINT_DEV, CLINT_MTIMECMP_OFS), '0, rd);
    check("timer_irq_o", 64'(timer_irq), 64'd1);
    issue(1'b1, MEM_WR, local_addr(m_core_id, CLINT_DEV, CLINT_MTIMECMP_OFS), '1, rd);
    check("timer_irq_o", 64'(timer_irq), 64'd0);
    issue(1'b0, MEM_RD, local_addr(m_core_id, CLINT_DEV, CLINT_MTIME_OFS), '0, t0);
    issue(1'b1, MEM_RD, local_addr(m_core_id, CLINT_DEV, CLINT_MTIME_OFS), '0, rd);
    check("mtime increasing", 64'(rd > t0), 64'd1);

    fork
      run_random(1'b0);
      run_random(1'b1);
    join
    check("cpu responses", 64'(resp_count[0]), 64'(accept_count[0]));
    check("io responses", 64'(resp_count[1]), 64'(accept_count[1]));
    check("mem commands", 64'(mem_cmd_count), 64'(mem_expected));

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== src/uncore_top.sv ====
module uncore_top
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // cpu requester
  input  logic                          cpu_cmd_v_i,
  output logic                          cpu_cmd_ready_o,
  input  uncore_pkg::mem_op_e           cpu_cmd_op_i,
  input  logic [uncore_pkg::ADDR_W-1:0] cpu_cmd_addr_i,
  input  logic [uncore_pkg::DATA_W-1:0] cpu_cmd_data_i,
  output logic                          cpu_resp_v_o,
  input  logic                          cpu_resp_ready_i,
  output logic [uncore_pkg::DATA_W-1:0] cpu_resp_data_o,
  // io requester
  input  logic                          io_cmd_v_i,
  output logic                          io_cmd_ready_o,
  input  uncore_pkg::mem_op_e           io_cmd_op_i,
  input  logic [uncore_pkg::ADDR_W-1:0] io_cmd_addr_i,
  input  logic [uncore_pkg::DATA_W-1:0] io_cmd_data_i,
  output logic                          io_resp_v_o,
  input  logic                          io_resp_ready_i,
  output logic [uncore_pkg::DATA_W-1:0] io_resp_data_o,
  // External memory, also carries off-tile traffic
  output logic                          mem_cmd_v_o,
  input  logic                          mem_cmd_ready_i,
  output uncore_pkg::mem_op_e           mem_cmd_op_o,
  output logic [uncore_pkg::ADDR_W-1:0] mem_cmd_addr_o,
  output logic [uncore_pkg::DATA_W-1:0] mem_cmd_data_o,
  input  logic                          mem_resp_v_i,
  output logic                          mem_resp_ready_o,
  input  logic [uncore_pkg::DATA_W-1:0] mem_resp_data_i,
  output logic                          freeze_o,
  output logic                          timer_irq_o,
  output logic                          software_irq_o
);
  import uncore_pkg::*;

  logic [TILE_W-1:0] core_id;

  dev_bus_if cfg_bus ();
  dev_bus_if clint_bus ();

  uncore_ctrl u_ctrl
  (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cpu_cmd_v_i      (cpu_cmd_v_i),
    .cpu_cmd_ready_o  (cpu_cmd_ready_o),
    .cpu_cmd_op_i     (cpu_cmd_op_i),
    .cpu_cmd_addr_i   (cpu_cmd_addr_i),
    .cpu_cmd_data_i   (cpu_cmd_data_i),
    .cpu_resp_v_o     (cpu_resp_v_o),
    .cpu_resp_ready_i (cpu_resp_ready_i),
    .cpu_resp_data_o  (cpu_resp_data_o),
    .io_cmd_v_i       (io_cmd_v_i),
    .io_cmd_ready_o   (io_cmd_ready_o),
    .io_cmd_op_i      (io_cmd_op_i),
    .io_cmd_addr_i    (io_cmd_addr_i),
    .io_cmd_data_i    (io_cmd_data_i),
    .io_resp_v_o      (io_resp_v_o),
    .io_resp_ready_i  (io_resp_ready_i),
    .io_resp_data_o   (io_resp_data_o),
    .mem_cmd_v_o      (mem_cmd_v_o),
    .mem_cmd_ready_i  (mem_cmd_ready_i),
    .mem_cmd_op_o     (mem_cmd_op_o),
    .mem_cmd_addr_o   (mem_cmd_addr_o),
    .mem_cmd_data_o   (mem_cmd_data_o),
    .mem_resp_v_i     (mem_resp_v_i),
    .mem_resp_ready_o (mem_resp_ready_o),
    .mem_resp_data_i  (mem_resp_data_i),
    .core_id_i        (core_id),
    .cfg_bus          (cfg_bus.ctrl),
    .clint_bus        (clint_bus.ctrl)
  );

  cfg_regs u_cfg
  (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .bus       (cfg_bus.dev),
    .freeze_o  (freeze_o),
    .core_id_o (core_id)
  );

  clint_slice u_clint
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .bus            (clint_bus.dev),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o)
  );

endmodule

// ==== src/clint_slice.sv ====
module clint_slice
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  dev_bus_if.dev bus,
  output logic   timer_irq_o,
  output logic   software_irq_o
);
  import uncore_pkg::*;

  logic [DATA_W-1:0] mtime_q, mtime_d;
  logic [DATA_W-1:0] mtimecmp_q, mtimecmp_d;
  logic              msip_q, msip_d;
  logic [DATA_W-1:0] rd_data;
  logic              wr;

  assign wr = bus.cmd_v && bus.cmd_wr;

  // Next state, a write to mtime replaces this cycle's increment
  always_comb
  begin
    mtime_d    = mtime_q + DATA_W'(1);
    mtimecmp_d = mtimecmp_q;
    msip_d     = msip_q;
    if (wr)
    begin
      case (bus.cmd_ofs)
        CLINT_MSIP_OFS:     msip_d     = bus.cmd_data[0];
        CLINT_MTIMECMP_OFS: mtimecmp_d = bus.cmd_data;
        CLINT_MTIME_OFS:    mtime_d    = bus.cmd_data;
        default:            msip_d     = msip_q;
      endcase
    end
  end

  always_comb
  begin
    case (bus.cmd_ofs)
      CLINT_MSIP_OFS:     rd_data = DATA_W'(msip_q);
      CLINT_MTIMECMP_OFS: rd_data = mtimecmp_q;
      CLINT_MTIME_OFS:    rd_data = mtime_q;
      default:            rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_o <= 1'b0;
      bus.resp_v  <= 1'b0;
    end
    else
    begin
      mtime_q     <= mtime_d;
      mtimecmp_q  <= mtimecmp_d;
      msip_q      <= msip_d;
      // Compare on next-state values so the irq tracks a write after one cycle
      timer_irq_o <= (mtime_d >= mtimecmp_d);
      bus.resp_v  <= bus.cmd_v;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (bus.cmd_v)
      bus.resp_data <= bus.cmd_wr ? '0 : rd_data;
  end

  assign software_irq_o = msip_q;

  a_no_irq_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> !timer_irq_o && !software_irq_o);

endmodule

// ==== src/cfg_regs.sv ====
module cfg_regs
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  dev_bus_if.dev                        bus,
  output logic                          freeze_o,
  output logic [uncore_pkg::TILE_W-1:0] core_id_o
);
  import uncore_pkg::*;

  logic              freeze_q;
  logic [TILE_W-1:0] core_id_q;
  logic [DATA_W-1:0] rd_data;
  logic              wr;

  assign wr = bus.cmd_v && bus.cmd_wr;

  always_comb
  begin
    case (bus.cmd_ofs)
      CFG_FREEZE_OFS:  rd_data = DATA_W'(freeze_q);
      CFG_CORE_ID_OFS: rd_data = DATA_W'(core_id_q);
      default:         rd_data = '0;
    endcase
  end

  // Core comes up frozen until software releases it
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      freeze_q  <= 1'b1;
      core_id_q <= '0;
      bus.resp_v <= 1'b0;
    end
    else
    begin
      bus.resp_v <= bus.cmd_v;
      if (wr && bus.cmd_ofs == CFG_FREEZE_OFS)
        freeze_q <= bus.cmd_data[0];
      if (wr && bus.cmd_ofs == CFG_CORE_ID_OFS)
        core_id_q <= bus.cmd_data[TILE_W-1:0];
    end
  end

  // Reads see the value held before this cycle's write
  always_ff @(posedge clk_i)
  begin
    if (bus.cmd_v)
      bus.resp_data <= bus.cmd_wr ? '0 : rd_data;
  end

  assign freeze_o  = freeze_q;
  assign core_id_o = core_id_q;

  a_resp_follows_cmd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus.resp_v == $past(bus.cmd_v));

endmodule

// ==== src/uncore_ctrl.sv ====
module uncore_ctrl
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          cpu_cmd_v_i,
  output logic                          cpu_cmd_ready_o,
  input  uncore_pkg::mem_op_e           cpu_cmd_op_i,
  input  logic [uncore_pkg::ADDR_W-1:0] cpu_cmd_addr_i,
  input  logic [uncore_pkg::DATA_W-1:0] cpu_cmd_data_i,
  output logic                          cpu_resp_v_o,
  input  logic                          cpu_resp_ready_i,
  output logic [uncore_pkg::DATA_W-1:0] cpu_resp_data_o,
  input  logic                          io_cmd_v_i,
  output logic                          io_cmd_ready_o,
  input  uncore_pkg::mem_op_e           io_cmd_op_i,
  input  logic [uncore_pkg::ADDR_W-1:0] io_cmd_addr_i,
  input  logic [uncore_pkg::DATA_W-1:0] io_cmd_data_i,
  output logic                          io_resp_v_o,
  input  logic                          io_resp_ready_i,
  output logic [uncore_pkg::DATA_W-1:0] io_resp_data_o,
  output logic                          mem_cmd_v_o,
  input  logic                          mem_cmd_ready_i,
  output uncore_pkg::mem_op_e           mem_cmd_op_o,
  output logic [uncore_pkg::ADDR_W-1:0] mem_cmd_addr_o,
  output logic [uncore_pkg::DATA_W-1:0] mem_cmd_data_o,
  input  logic                          mem_resp_v_i,
  output logic                          mem_resp_ready_o,
  input  logic [uncore_pkg::DATA_W-1:0] mem_resp_data_i,
  input  logic [uncore_pkg::TILE_W-1:0] core_id_i,
  dev_bus_if.ctrl                       cfg_bus,
  dev_bus_if.ctrl                       clint_bus
);
  import uncore_pkg::*;

  ctrl_state_e        state_q, state_d;
  logic [NUM_SRC-1:0] req, gnt;
  logic               accept, rr_q, src_q, resp_v, resp_ready, dev_resp_v;
  mem_op_e            sel_op, op_q;
  logic [ADDR_W-1:0]  sel_addr, addr_q;
  logic [DATA_W-1:0]  sel_data, wdata_q, resp_data_q;
  dest_e              sel_dest, dest_q;

  function automatic dest_e decode(input logic [ADDR_W-1:0] addr,
                                   input logic [TILE_W-1:0] core_id);
    logic [DEV_W-1:0] dev;
    dev = addr[DEV_LSB +: DEV_W];
    if (addr >= DRAM_BASE || addr[TILE_LSB +: TILE_W] != core_id)
      decode = DEST_MEM;
    else if (dev == CFG_DEV)
      decode = DEST_CFG;
    else if (dev == CLINT_DEV)
      decode = DEST_CLINT;
    else
      decode = DEST_LOOP;
  endfunction

  // Round robin, rr_q set means io wins a tie
  assign req = {io_cmd_v_i, cpu_cmd_v_i};
  always_comb
  begin
    gnt = '0;
    if (state_q == ST_IDLE)
    begin
      if (req[SRC_CPU] && (!req[SRC_IO] || !rr_q))
        gnt[SRC_CPU] = 1'b1;
      else if (req[SRC_IO])
        gnt[SRC_IO] = 1'b1;
    end
  end
  assign accept          = |gnt;
  assign cpu_cmd_ready_o = gnt[SRC_CPU];
  assign io_cmd_ready_o  = gnt[SRC_IO];

  assign sel_op   = gnt[SRC_IO] ? io_cmd_op_i   : cpu_cmd_op_i;
  assign sel_addr = gnt[SRC_IO] ? io_cmd_addr_i : cpu_cmd_addr_i;
  assign sel_data = gnt[SRC_IO] ? io_cmd_data_i : cpu_cmd_data_i;
  assign sel_dest = decode(sel_addr, core_id_i);

  assign dev_resp_v = (dest_q == DEST_CFG) ? cfg_bus.resp_v : clint_bus.resp_v;
  assign resp_ready = src_q ? io_resp_ready_i : cpu_resp_ready_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
        if (accept)
        begin
          case (sel_dest)
            DEST_CFG, DEST_CLINT: state_d = ST_DEV_ISSUE;
            DEST_MEM:             state_d = ST_MEM_CMD;
            default:              state_d = ST_RESP;
          endcase
        end
      ST_DEV_ISSUE: state_d = ST_DEV_WAIT;
      ST_DEV_WAIT:  state_d = dev_resp_v ? ST_RESP : ST_DEV_WAIT;
      ST_MEM_CMD:   state_d = mem_cmd_ready_i ? ST_MEM_WAIT : ST_MEM_CMD;
      ST_MEM_WAIT:  state_d = mem_resp_v_i ? ST_RESP : ST_MEM_WAIT;
      ST_RESP:      state_d = resp_ready ? ST_IDLE : ST_RESP;
      default:      state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= ST_IDLE;
      rr_q    <= 1'b0;
      src_q   <= 1'b0;
      dest_q  <= DEST_LOOP;
    end
    else
    begin
      state_q <= state_d;
      if (accept)
      begin
        rr_q   <= ~rr_q;
        src_q  <= gnt[SRC_IO];
        dest_q <= sel_dest;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      op_q    <= sel_op;
      addr_q  <= sel_addr;
      wdata_q <= sel_data;
    end
    // Loopback answers zero for reads and writes alike
    if (accept && sel_dest == DEST_LOOP)
      resp_data_q <= '0;
    else if (state_q == ST_DEV_WAIT && dev_resp_v)
      resp_data_q <= (dest_q == DEST_CFG) ? cfg_bus.resp_data : clint_bus.resp_data;
    else if (state_q == ST_MEM_WAIT && mem_resp_v_i)
      resp_data_q <= mem_resp_data_i;
  end

  assign cfg_bus.cmd_v    = (state_q == ST_DEV_ISSUE) && (dest_q == DEST_CFG);
  assign cfg_bus.cmd_wr   = (op_q == MEM_WR);
  assign cfg_bus.cmd_ofs  = addr_q[OFFSET_W-1:0];
  assign cfg_bus.cmd_data = wdata_q;

  assign clint_bus.cmd_v    = (state_q == ST_DEV_ISSUE) && (dest_q == DEST_CLINT);
  assign clint_bus.cmd_wr   = (op_q == MEM_WR);
  assign clint_bus.cmd_ofs  = addr_q[OFFSET_W-1:0];
  assign clint_bus.cmd_data = wdata_q;

  assign mem_cmd_v_o      = (state_q == ST_MEM_CMD);
  assign mem_cmd_op_o     = op_q;
  assign mem_cmd_addr_o   = addr_q;
  assign mem_cmd_data_o   = wdata_q;
  assign mem_resp_ready_o = (state_q == ST_MEM_WAIT);

  assign resp_v          = (state_q == ST_RESP);
  assign cpu_resp_v_o    = resp_v && !src_q;
  assign io_resp_v_o     = resp_v && src_q;
  assign cpu_resp_data_o = resp_data_q;
  assign io_resp_data_o  = resp_data_q;

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({io_cmd_ready_o, cpu_cmd_ready_o}));
  a_cpu_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cpu_resp_v_o && !cpu_resp_ready_i |=> cpu_resp_v_o && $stable(cpu_resp_data_o));
  a_io_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    io_resp_v_o && !io_resp_ready_i |=> io_resp_v_o && $stable(io_resp_data_o));
  a_mem_cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_cmd_v_o && !mem_cmd_ready_i |=> mem_cmd_v_o && $stable(mem_cmd_addr_o));

endmodule

// ==== src/dev_bus_if.sv ====
interface dev_bus_if;
  import uncore_pkg::*;

  // Command side, one-cycle pulse per command
  logic                cmd_v;
  logic                cmd_wr;
  logic [OFFSET_W-1:0] cmd_ofs;
  logic [DATA_W-1:0]   cmd_data;

  // Response side, one pulse on the cycle after cmd_v
  logic                resp_v;
  logic [DATA_W-1:0]   resp_data;

  modport ctrl
  (
    output cmd_v,
    output cmd_wr,
    output cmd_ofs,
    output cmd_data,
    input  resp_v,
    input  resp_data
  );

  modport dev
  (
    input  cmd_v,
    input  cmd_wr,
    input  cmd_ofs,
    input  cmd_data,
    output resp_v,
    output resp_data
  );
endinterface

// ==== src/uncore_pkg.sv ====
package uncore_pkg;

  // Widths
  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 64;
  localparam int OFFSET_W = 20;
  localparam int DEV_W    = 4;
  localparam int TILE_W   = 4;

  // Field positions in a local address
  localparam int DEV_LSB  = OFFSET_W;
  localparam int TILE_LSB = OFFSET_W + DEV_W;

  // Address map
  localparam logic [ADDR_W-1:0] DRAM_BASE = 32'h8000_0000;

  localparam logic [DEV_W-1:0] CFG_DEV   = 4'd1;
  localparam logic [DEV_W-1:0] CLINT_DEV = 4'd2;

  localparam logic [OFFSET_W-1:0] CFG_FREEZE_OFS  = 20'h0_0000;
  localparam logic [OFFSET_W-1:0] CFG_CORE_ID_OFS = 20'h0_0008;

  localparam logic [OFFSET_W-1:0] CLINT_MSIP_OFS     = 20'h0_0000;
  localparam logic [OFFSET_W-1:0] CLINT_MTIMECMP_OFS = 20'h0_4000;
  localparam logic [OFFSET_W-1:0] CLINT_MTIME_OFS    = 20'h0_BFF8;

  // Requesters
  localparam int NUM_SRC = 2;
  localparam int SRC_CPU = 0;
  localparam int SRC_IO  = 1;

  typedef enum logic
  {
    MEM_RD = 1'b0,
    MEM_WR = 1'b1
  } mem_op_e;

  typedef enum logic [1:0]
  {
    DEST_CFG   = 2'd0,
    DEST_CLINT = 2'd1,
    DEST_MEM   = 2'd2,
    DEST_LOOP  = 2'd3
  } dest_e;

  // One command in flight, so the sequencer walks a single path per command
  typedef enum logic [2:0]
  {
    ST_IDLE      = 3'd0,
    ST_DEV_ISSUE = 3'd1,
    ST_DEV_WAIT  = 3'd2,
    ST_MEM_CMD   = 3'd3,
    ST_MEM_WAIT  = 3'd4,
    ST_RESP      = 3'd5
  } ctrl_state_e;

endpackage
